/* Bender.yml */
package:
  name: opcode_cipher

sources:
  - include_dirs:
      - src
    files:
      - src/cipher_pkg.sv
      - src/key_table_if.sv
      - src/key_table_arb.sv
      - src/cipher_cfg_apb.sv
      - src/opcode_decrypt.sv
      - src/cipher_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - sim/cipher_tb.sv

/* flist.f */
+incdir+src
src/cipher_pkg.sv
src/key_table_if.sv
src/key_table_arb.sv
src/cipher_cfg_apb.sv
src/opcode_decrypt.sv
src/cipher_top.sv
sim/cipher_tb.sv

/* sim/cipher_tb.sv */
`default_nettype none

`include "cipher_settings.svh"

module cipher_tb
    import cipher_pkg::*;
();

    localparam int APB_WAIT   = 64;  // max cycles for one APB transfer
    localparam int T1_CYCLES  = 10 * 4;
    localparam int T2_CYCLES  = 64 * 4;
    localparam int T3_CYCLES  = 16 + 20;
    localparam int T4_CYCLES  = 4 * (3 * 4 + 2 * 24 + 20);
    localparam int T5_CYCLES  = 8 + 20;
    localparam int T6_CYCLES  = 2 * (24 + 3 * 4 + 20);
    localparam int MAX_CYCLES = 10 + T1_CYCLES + T2_CYCLES + T3_CYCLES + T4_CYCLES
                                + T5_CYCLES + T6_CYCLES + 300;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               psel, penable, pwrite;
    logic [`APB_AW-1:0] paddr;
    logic [31:0]        pwdata, prdata;
    logic               pready, pslverr;
    logic               fetch_valid, fetch_op_n, dec_valid;
    logic [23:1]        fetch_addr;
    word_t              fetch_enc, dec_word;

    int          errors = 0;
    int          cyc = 0;
    int          done_cyc;     // cycle the last APB transfer ended
    int          stream_end;   // cycle of the last fetch in a stream
    key_t        key_mem [2**`KEY_AW];  // model copy of the table
    gkeys_t      gk = '0;               // model copy of the globals
    int          pool [$];              // table indices written so far
    word_t       exp_word [$];
    int          exp_cyc [$];
    logic [31:0] rd;
    logic        err;

    cipher_top DUT (.*);

    always #50 clk = ~clk;

    // watchdog
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Error %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_key(input string name, input key_t got, input key_t exp);
        if (got !== exp) begin
            $display("Error %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error %0t: %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    // dec_word checked mid-cycle against the oldest pending fetch
    always @(negedge clk) begin
        if (rst_n && dec_valid) begin
            if (exp_word.size() == 0) begin
                $display("%0t: dec_valid high with no fetch outstanding", $time);
                errors++;
            end else begin
                if (cyc != exp_cyc[0] + `DEC_LATENCY) begin
                    $display("%0t: dec_valid came %0d cycles after its fetch", $time,
                             cyc - exp_cyc[0]);
                    errors++;
                end
                check_word("dec_word", dec_word, exp_word[0]);
                exp_word.delete(0);
                exp_cyc.delete(0);
            end
        end
    end

    function automatic word_t rotl(input word_t w, input int n);
        word_t r;
        r = w;
        for (int i = 0; i < n; i++)
            r = {r[14:0], r[15]};
        return r;
    endfunction

    function automatic word_t rotr(input word_t w, input int n);
        word_t r;
        r = w;
        for (int i = 0; i < n; i++)
            r = {r[0], r[15:1]};
        return r;
    endfunction

    // reference for an opcode fetch
    function automatic word_t model(input word_t enc, input key_t tkey);
        key_t  k;
        word_t w;
        k = tkey ^ gk.g1;
        w = enc ^ {gk.g2, gk.g3};
        if (k[0])
            w = {w[7:0], w[15:8]};
        w = rotl(w, k[7:4]);
        if (k[1])
            w[3:0] = ~w[3:0];
        if (w[15:12] == 4'hf || (w >= 16'h4e80 && w <= 16'h4eff))
            w = 16'hffff;  // forbidden classes
        return w;
    endfunction

    // steps of model() undone in reverse order, without the masking
    function automatic word_t make_enc(input word_t plain, input key_t tkey);
        key_t  k;
        word_t w;
        k = tkey ^ gk.g1;
        w = plain;
        if (k[1])
            w[3:0] = ~w[3:0];
        w = rotr(w, k[7:4]);
        if (k[0])
            w = {w[7:0], w[15:8]};
        return w ^ {gk.g2, gk.g3};
    endfunction

    function automatic key_t gkey(input int idx);
        return idx == 0 ? gk.g1 : idx == 1 ? gk.g2 : gk.g3;
    endfunction

    task automatic apb_xfer(input logic wr, input logic [`APB_AW-1:0] addr,
                            input logic [31:0] wdata);
        int n;
        n = 0;
        @(posedge clk);
        #10;
        psel   = 1'b1;  // setup phase
        pwrite = wr;
        paddr  = addr;
        pwdata = wdata;
        @(posedge clk);
        #10;
        penable = 1'b1;
        @(negedge clk);
        while (!pready && n < APB_WAIT) begin
            n++;
            @(negedge clk);
        end
        if (!pready) begin
            $display("%0t: pready never came for paddr %h", $time, addr);
            errors++;
        end
        rd       = prdata;
        err      = pslverr;
        done_cyc = cyc;
        @(posedge clk);
        #10;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_global(input int idx, input key_t val);
        apb_xfer(1'b1, idx << 2, {24'd0, val});
        case (idx)
            0:       gk.g1 = val;
            1:       gk.g2 = val;
            default: gk.g3 = val;
        endcase
    endtask

    task automatic read_global(input int idx);
        apb_xfer(1'b0, idx << 2, 32'd0);
        check_key("prdata", rd[7:0], gkey(idx));
        check_bit("pslverr", err, 1'b0);
    endtask

    task automatic write_entry(input int idx, input key_t val);
        apb_xfer(1'b1, (1 << `TABLE_SEL_BIT) | idx, {24'd0, val});
        key_mem[idx] = val;
        pool.push_back(idx);
    endtask

    task automatic read_entry(input int idx);
        apb_xfer(1'b0, (1 << `TABLE_SEL_BIT) | idx, 32'd0);
        check_key("prdata", rd[7:0], key_mem[idx]);
    endtask

    task automatic issue_fetch(input logic op_n, input int idx, input word_t enc);
        @(posedge clk);
        #10;
        fetch_valid = 1'b1;
        fetch_op_n  = op_n;
        fetch_addr  = {10'($urandom), 13'(idx)};  // upper bits don't pick the key
        fetch_enc   = enc;
        exp_word.push_back(op_n ? enc : model(enc, key_mem[idx]));
        exp_cyc.push_back(cyc);
    endtask

    task automatic idle();
        @(posedge clk);
        #10;
        fetch_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        idle();
        while (exp_word.size() != 0 && n < 16) begin
            @(posedge clk);
            n++;
        end
        if (exp_word.size() != 0) begin
            $display("%0t: dec_valid missing for %0d fetches", $time, exp_word.size());
            errors++;
            exp_word.delete();
            exp_cyc.delete();
        end
    endtask

    task automatic opcode_stream(input int n, input logic gaps);
        for (int i = 0; i < n; i++) begin
            issue_fetch(1'b0, pool[$urandom % pool.size()], word_t'($urandom));
            if (gaps && $urandom % 4 == 0)
                idle();
        end
        stream_end = cyc;
        idle();
    endtask

    task automatic test_globals();
        check_bit("dec_valid", dec_valid, 1'b0);
        check_bit("pslverr", pslverr, 1'b0);
        for (int i = 0; i < 3; i++)
            read_global(i);  // model still zero here
        for (int i = 0; i < 3; i++)
            write_global(i, key_t'($urandom));
        for (int i = 0; i < 3; i++)
            read_global(i);
        apb_xfer(1'b0, 3 << 2, 32'd0);
        check_bit("pslverr", err, 1'b1);
    endtask

    task automatic test_table();
        for (int i = 0; i < 32; i++)
            write_entry($urandom % (1 << `KEY_AW), key_t'($urandom));
        foreach (pool[i])
            read_entry(pool[i]);
    endtask

    task automatic test_data();
        for (int i = 0; i < 16; i++)
            issue_fetch(1'b1, $urandom % (1 << `KEY_AW), word_t'($urandom));
        wait_drain();
    endtask

    task automatic test_opcodes();
        for (int r = 0; r < 4; r++) begin
            for (int i = 0; i < 3; i++)
                write_global(i, key_t'($urandom));
            opcode_stream(24, r % 2);  // even rounds back to back
            wait_drain();
        end
    endtask

    task automatic test_forbidden();
        int    idx;
        word_t w;
        word_t enc;
        for (int i = 0; i < 8; i++) begin
            idx = pool[$urandom % pool.size()];
            w   = word_t'($urandom);
            if (i % 2 == 0)
                w[15:12] = 4'hf;
            else
                w = {9'b0100_1110_1, w[6:0]};  // 4E80..4EFF
            enc = make_enc(w, key_mem[idx]);
            issue_fetch(1'b0, idx, enc);
        end
        wait_drain();
    endtask

    // config reads starve while the decoder owns the table
    task automatic test_contention();
        int idx;
        for (int r = 0; r < 2; r++) begin
            idx = pool[$urandom % pool.size()];
            fork
                opcode_stream(24, 1'b0);
                begin
                    repeat (3) @(posedge clk);
                    read_entry(idx);
                end
            join
            if (done_cyc <= stream_end) begin
                $display("%0t: key table read finished during the fetch stream", $time);
                errors++;
            end
            wait_drain();
        end
    endtask

    initial begin
        void'($urandom(32));
        rst_n       = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        fetch_valid = 1'b0;
        fetch_op_n  = 1'b0;
        fetch_addr  = '0;
        fetch_enc   = '0;
        repeat (5) @(posedge clk);
        #10;
        rst_n = 1'b1;
        test_globals();
        test_table();
        test_data();
        test_opcodes();
        test_forbidden();
        test_contention();
        $display("errors: %0d", errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* src/cipher_cfg_apb.sv */
`default_nettype none

`include "cipher_settings.svh"

module cipher_cfg_apb
    import cipher_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [`APB_AW-1:0]  paddr,
    input  logic [31:0]         pwdata,
    output logic [31:0]         prdata,
    output logic                pready,
    output logic                pslverr,
    output gkeys_t              gkeys,
    key_table_if.requester      tbl
);

    logic                        access;
    logic                        sel_tbl;
    logic [`TABLE_SEL_BIT-3:0]   gidx;   // word index above byte offset
    logic                        gidx_ok;
    logic                        glb_wr;
    logic                        rd_pend;
    key_t                        glb_rdata;

    assign access  = psel & penable;
    assign sel_tbl = paddr[`TABLE_SEL_BIT];
    assign gidx    = paddr[`TABLE_SEL_BIT-1:2];
    assign gidx_ok = gidx < 3;
    assign glb_wr  = access & ~sel_tbl & pwrite & gidx_ok;

    // table request held until granted, dropped while read data is due
    assign tbl.req   = access & sel_tbl & ~rd_pend;
    assign tbl.we    = pwrite;
    assign tbl.addr  = paddr[`KEY_AW-1:0];
    assign tbl.wdata = pwdata[7:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gkeys   <= '0;
            rd_pend <= 1'b0;
        end else begin
            rd_pend <= tbl.req & tbl.gnt & ~pwrite;  // data arrives next cycle
            if (glb_wr) begin
                case (gidx[1:0])
                    2'd0:    gkeys.g1 <= pwdata[7:0];
                    2'd1:    gkeys.g2 <= pwdata[7:0];
                    default: gkeys.g3 <= pwdata[7:0];
                endcase
            end
        end
    end

    always_comb begin
        case (gidx)
            0:       glb_rdata = gkeys.g1;
            1:       glb_rdata = gkeys.g2;
            2:       glb_rdata = gkeys.g3;
            default: glb_rdata = '0;
        endcase
    end

    assign prdata = {24'd0, sel_tbl ? tbl.rdata : glb_rdata};

    // globals finish at once, table waits on the arbiter
    always_comb begin
        if (!access)
            pready = 1'b0;
        else if (!sel_tbl)
            pready = 1'b1;
        else if (pwrite)
            pready = tbl.gnt;
        else
            pready = rd_pend;
    end

    assign pslverr = access & ~sel_tbl & ~gidx_ok;

    // APB access phase only follows a setup phase
    a_penable_psel : assert property (
        @(posedge clk) disable iff (!rst_n)
        penable |-> psel
    );

endmodule

`default_nettype wire

/* src/cipher_pkg.sv */
`default_nettype none

`include "cipher_settings.svh"

package cipher_pkg;

    // one program ROM word
    typedef logic [15:0] word_t;

    // per-address or global key byte
    typedef logic [7:0] key_t;

    // key table index
    typedef logic [`KEY_AW-1:0] key_addr_t;

    // the three global keys loaded over APB
    typedef struct packed {
        key_t g1;   // mixed into the table byte
        key_t g2;   // xor on high byte
        key_t g3;   // xor on low byte
    } gkeys_t;

    // one CPU fetch as seen by the decoder
    typedef struct packed {
        logic [23:1] addr;  // word address
        logic        op_n;  // 1 = data fetch, 0 = opcode
        word_t       enc;   // word as read from ROM
    } fetch_t;

endpackage

`default_nettype wire

/* src/cipher_settings.svh */
`ifndef CIPHER_SETTINGS_SVH
`define CIPHER_SETTINGS_SVH

// key table geometry, 8192 entries
`define KEY_AW 13

// APB address width seen by the config block
`define APB_AW 16

// paddr bit picking key table (1) over global key regs (0)
`define TABLE_SEL_BIT 14

// cycles from fetch_valid to dec_valid
`define DEC_LATENCY 2

`endif

/* src/cipher_top.sv */
`default_nettype none

`include "cipher_settings.svh"

module cipher_top
    import cipher_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,

    // APB config port
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [`APB_AW-1:0] paddr,
    input  logic [31:0]        pwdata,
    output logic [31:0]        prdata,
    output logic               pready,
    output logic               pslverr,

    // fetch path, valid only
    input  logic               fetch_valid,
    input  logic [23:1]        fetch_addr,
    input  logic               fetch_op_n,
    input  word_t              fetch_enc,
    output logic               dec_valid,
    output word_t              dec_word
);

    fetch_t fetch;
    gkeys_t gkeys;

    key_table_if dec_if ();
    key_table_if cfg_if ();

    assign fetch = '{addr: fetch_addr, op_n: fetch_op_n, enc: fetch_enc};

    cipher_cfg_apb u_cfg (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .gkeys   (gkeys),
        .tbl     (cfg_if.requester)
    );

    opcode_decrypt u_dec (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_valid (fetch_valid),
        .fetch       (fetch),
        .gkeys       (gkeys),
        .tbl         (dec_if.requester),
        .dec_valid   (dec_valid),
        .dec_word    (dec_word)
    );

    key_table_arb u_arb (
        .clk      (clk),
        .rst_n    (rst_n),
        .dec_port (dec_if.arbiter),
        .cfg_port (cfg_if.arbiter)
    );

endmodule

`default_nettype wire

/* src/key_table_arb.sv */
`default_nettype none

`include "cipher_settings.svh"

module key_table_arb
    import cipher_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    key_table_if.arbiter dec_port,
    key_table_if.arbiter cfg_port
);

    key_t      mem [2**`KEY_AW];
    logic      sel_cfg;
    logic      acc;
    logic      acc_we;
    key_addr_t acc_addr;
    key_t      acc_wdata;
    key_t      rd_q;
    logic      dec_rd_q;
    logic      cfg_rd_q;

    // decoder always wins, config only gets idle cycles
    assign dec_port.gnt = dec_port.req;
    assign cfg_port.gnt = cfg_port.req & ~dec_port.req;

    assign sel_cfg   = cfg_port.gnt;
    assign acc       = dec_port.gnt | cfg_port.gnt;
    assign acc_we    = sel_cfg ? cfg_port.we    : dec_port.we;
    assign acc_addr  = sel_cfg ? cfg_port.addr  : dec_port.addr;
    assign acc_wdata = sel_cfg ? cfg_port.wdata : dec_port.wdata;

    // single port: one read or one write per cycle
    always_ff @(posedge clk) begin
        if (acc) begin
            if (acc_we)
                mem[acc_addr] <= acc_wdata;
            else
                rd_q <= mem[acc_addr];
        end
    end

    // remember who owns the read data in the next cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_rd_q <= 1'b0;
            cfg_rd_q <= 1'b0;
        end else begin
            dec_rd_q <= dec_port.gnt & ~dec_port.we;
            cfg_rd_q <= cfg_port.gnt & ~cfg_port.we;
        end
    end

    assign dec_port.rdata = dec_rd_q ? rd_q : '0;
    assign cfg_port.rdata = cfg_rd_q ? rd_q : '0;

    // the memory has one port, so one owner per cycle
    a_one_grant : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(dec_port.gnt && cfg_port.gnt)
    );

endmodule

`default_nettype wire

/* src/key_table_if.sv */
`default_nettype none

`include "cipher_settings.svh"

// one requester's view of the shared key table
interface key_table_if
    import cipher_pkg::*;
();

    logic      req;
    logic      we;
    key_addr_t addr;
    key_t      wdata;
    logic      gnt;    // accepted when req & gnt
    key_t      rdata;  // valid one cycle after a granted read

    modport requester (
        output req, we, addr, wdata,
        input  gnt, rdata
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output gnt, rdata
    );

endinterface

`default_nettype wire

/* src/opcode_decrypt.sv */
`default_nettype none

`include "cipher_settings.svh"

module opcode_decrypt
    import cipher_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  logic           fetch_valid,
    input  fetch_t         fetch,
    input  gkeys_t         gkeys,
    key_table_if.requester tbl,
    output logic           dec_valid,
    output word_t          dec_word
);

    logic   s1_valid;
    fetch_t s1_fetch;
    word_t  plain;

    // compact cipher: key mix, xor, swap, rotate, nibble flip, masking
    function automatic word_t decrypt(input word_t enc, input key_t tkey, input gkeys_t gk);
        key_t        k;
        word_t       w;
        logic [31:0] dbl;
        begin
            k = tkey ^ gk.g1;
            w = enc ^ {gk.g2, gk.g3};
            if (k[0])
                w = {w[7:0], w[15:8]};  // byte swap
            dbl = {w, w} << k[7:4];     // rotate left through doubled word
            w = dbl[31:16];
            if (k[1])
                w[3:0] = ~w[3:0];
            // forbidden opcode classes
            if (w[15:12] == 4'hf || (w & 16'hff80) == 16'h4e80)
                w = 16'hffff;
            decrypt = w;
        end
    endfunction

    // stage 1: look the key up, only opcodes need it
    assign tbl.req   = fetch_valid & ~fetch.op_n;
    assign tbl.we    = 1'b0;
    assign tbl.addr  = fetch.addr[13:1];
    assign tbl.wdata = '0;

    always_ff @(posedge clk) begin
        if (!rst_n)
            s1_valid <= 1'b0;
        else
            s1_valid <= fetch_valid;
    end

    always_ff @(posedge clk) begin
        s1_fetch <= fetch;
    end

    // stage 2: table byte arrives now, globals sampled here too
    assign plain = s1_fetch.op_n ? s1_fetch.enc : decrypt(s1_fetch.enc, tbl.rdata, gkeys);

    always_ff @(posedge clk) begin
        if (!rst_n)
            dec_valid <= 1'b0;
        else
            dec_valid <= s1_valid;
    end

    always_ff @(posedge clk) begin
        if (s1_valid)
            dec_word <= plain;
    end

    // fixed latency, opcode and data alike
    a_latency : assert property (
        @(posedge clk) disable iff (!rst_n)
        ($past(rst_n, 1) && $past(rst_n, `DEC_LATENCY))
            |-> dec_valid == $past(fetch_valid, `DEC_LATENCY)
    );

    // no stall path on fetches, so the arbiter must never hold us off
    a_always_granted : assert property (
        @(posedge clk) disable iff (!rst_n)
        tbl.req |-> tbl.gnt
    );

endmodule

`default_nettype wire
